// ==== hdl/layer_ctrl_if.sv ====
`timescale 1ns/100ps

// per-layer control bundle, scroll and fetch position plus the map write port
interface layer_ctrl_if;

	tilegen_pkg::scroll_t    scroll_x;
	tilegen_pkg::scroll_t    scroll_y;
	// on-screen position after flip, same cycle as the counters
	tilegen_pkg::coord_t     fetch_x;
	tilegen_pkg::coord_t     fetch_y;
	// single cycle write strobe from the cpu decode
	logic                    map_we;
	tilegen_pkg::map_addr_t  map_addr;
	tilegen_pkg::map_entry_t map_wdata;

	modport control (
		output scroll_x, scroll_y,
		output fetch_x, fetch_y,
		output map_we, map_addr, map_wdata
	);

	modport layer (
		input scroll_x, scroll_y,
		input fetch_x, fetch_y,
		input map_we, map_addr, map_wdata
	);

endinterface

// ==== hdl/layer_mixer.sv ====
`timescale 1ns/100ps

module layer_mixer (
	input  logic                  clk_6m,
	input  logic                  rst_n,
	input  tilegen_pkg::pixel_t   pixel0,
	input  tilegen_pkg::palette_t palette0,
	input  logic                  priority0,
	input  tilegen_pkg::pixel_t   pixel1,
	input  tilegen_pkg::palette_t palette1,
	input  logic                  priority1,
	input  tilegen_pkg::dot_t     back_color,
	output tilegen_pkg::dot_t     dot
);

	logic              opaque0;
	logic              opaque1;
	tilegen_pkg::dot_t dot0;
	tilegen_pkg::dot_t dot1;
	tilegen_pkg::dot_t dot_next;

	assign opaque0 = pixel0 != tilegen_pkg::pixel_t'(tilegen_pkg::TRANSPARENT_PIXEL);
	assign opaque1 = pixel1 != tilegen_pkg::pixel_t'(tilegen_pkg::TRANSPARENT_PIXEL);

	// palette picks the group of eight, pixel the entry inside it
	assign dot0 = {palette0, pixel0};
	assign dot1 = {palette1, pixel1};

	////////////////////////////////////////////////////////////
	// priority select
	////////////////////////////////////////////////////////////

	always_comb begin
		if (opaque0 && priority0)
			// layer 0 tile raised above layer 1
			dot_next = dot0;
		else if (opaque1)
			dot_next = dot1;
		else if (opaque0)
			dot_next = dot0;
		else
			dot_next = back_color;
	end

	// output register, stage 3
	always_ff @(posedge clk_6m) begin
		if (!rst_n)
			dot <= '0;
		else
			dot <= dot_next;
	end

endmodule

// ==== hdl/tile_fetch_if.sv ====
`timescale 1ns/100ps

// pattern lookup from one layer into the shared pattern ram
interface tile_fetch_if;

	tilegen_pkg::tile_code_t code;
	// pixel position inside the 8x8 tile
	logic [2:0]              fine_x;
	logic [2:0]              fine_y;
	// registered, one clock after the request
	tilegen_pkg::pixel_t     pixel;

	modport request (
		output code, fine_x, fine_y,
		input  pixel
	);

	modport lookup (
		input  code, fine_x, fine_y,
		output pixel
	);

endinterface

// ==== hdl/tile_layer.sv ====
`timescale 1ns/100ps

module tile_layer (
	input  logic                  clk_6m,
	layer_ctrl_if.layer           ctrl,
	tile_fetch_if.request         fetch,
	output tilegen_pkg::pixel_t   pixel,
	output tilegen_pkg::palette_t palette,
	output logic                  priority_bit
);

	// 32 x 32 tiles of 8 x 8 pixels
	tilegen_pkg::map_entry_t map_ram [1024];

	tilegen_pkg::scroll_t    map_x;
	tilegen_pkg::scroll_t    map_y;
	tilegen_pkg::map_addr_t  rd_addr;
	tilegen_pkg::map_entry_t entry;
	logic [2:0]              fine_x_d;
	logic [2:0]              fine_y_d;

	////////////////////////////////////////////////////////////
	// stage 0, scrolled plane position
	////////////////////////////////////////////////////////////

	// 8 bit add wraps the plane at 256
	assign map_x = ctrl.fetch_x[7:0] + ctrl.scroll_x;
	assign map_y = ctrl.fetch_y[7:0] + ctrl.scroll_y;
	// row major, tile row in the upper five bits
	assign rd_addr = {map_y[7:3], map_x[7:3]};

	// cpu port
	always_ff @(posedge clk_6m) begin
		if (ctrl.map_we)
			map_ram[ctrl.map_addr] <= ctrl.map_wdata;
	end

	////////////////////////////////////////////////////////////
	// stage 1, entry valid and pattern request out
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_6m) begin
		entry    <= map_ram[rd_addr];
		// fine bits ride along with the map read
		fine_x_d <= map_x[2:0];
		fine_y_d <= map_y[2:0];
	end

	assign fetch.code   = entry[tilegen_pkg::ENTRY_CODE_LSB +: $bits(tilegen_pkg::tile_code_t)];
	assign fetch.fine_x = fine_x_d;
	assign fetch.fine_y = fine_y_d;

	////////////////////////////////////////////////////////////
	// stage 2, pixel back from pattern ram
	////////////////////////////////////////////////////////////

	// attributes held one more clock to meet the pixel
	always_ff @(posedge clk_6m) begin
		palette      <= entry[tilegen_pkg::ENTRY_PALETTE_LSB +: $bits(tilegen_pkg::palette_t)];
		priority_bit <= entry[tilegen_pkg::ENTRY_PRIORITY_BIT];
	end

	assign pixel = fetch.pixel;

endmodule

// ==== hdl/tile_pattern.sv ====
`timescale 1ns/100ps

module tile_pattern (
	input  logic                       clk_6m,
	input  logic                       pattern_we,
	input  tilegen_pkg::pattern_addr_t pattern_addr,
	input  tilegen_pkg::pixel_t        pattern_wdata,
	tile_fetch_if.lookup               fetch0,
	tile_fetch_if.lookup               fetch1
);

	// 64 tiles of 64 pixels, one pixel per word
	tilegen_pkg::pixel_t pattern_ram [4096];

	tilegen_pkg::pattern_addr_t rd_addr0;
	tilegen_pkg::pattern_addr_t rd_addr1;

	////////////////////////////////////////////////////////////
	// address is code * 64 + fine_y * 8 + fine_x
	////////////////////////////////////////////////////////////

	assign rd_addr0 = {fetch0.code, fetch0.fine_y, fetch0.fine_x};
	assign rd_addr1 = {fetch1.code, fetch1.fine_y, fetch1.fine_x};

	// cpu write port
	always_ff @(posedge clk_6m) begin
		if (pattern_we)
			pattern_ram[pattern_addr] <= pattern_wdata;
	end

	// layer read ports, both one clock deep
	always_ff @(posedge clk_6m) begin
		fetch0.pixel <= pattern_ram[rd_addr0];
		fetch1.pixel <= pattern_ram[rd_addr1];
	end

endmodule

// ==== hdl/tilegen_control.sv ====
`timescale 1ns/100ps

module tilegen_control (
	input  logic                       clk_6m,
	input  logic                       rst_n,
	input  tilegen_pkg::cpu_addr_t     cpu_addr,
	input  logic                       cpu_we,
	input  tilegen_pkg::cpu_data_t     cpu_wdata,
	layer_ctrl_if.control              layer0,
	layer_ctrl_if.control              layer1,
	output logic                       pattern_we,
	output tilegen_pkg::pattern_addr_t pattern_addr,
	output tilegen_pkg::pixel_t        pattern_wdata,
	output tilegen_pkg::dot_t          back_color,
	output logic                       de,
	output logic                       hsync,
	output logic                       vsync
);

	tilegen_pkg::coord_t  h_count;
	tilegen_pkg::coord_t  v_count;
	tilegen_pkg::scroll_t scroll0_x;
	tilegen_pkg::scroll_t scroll0_y;
	tilegen_pkg::scroll_t scroll1_x;
	tilegen_pkg::scroll_t scroll1_y;
	logic                 flip;
	logic [1:0]           region;
	logic [tilegen_pkg::PIPE_LATENCY-1:0] de_pipe;
	logic [tilegen_pkg::PIPE_LATENCY-1:0] hs_pipe;
	logic [tilegen_pkg::PIPE_LATENCY-1:0] vs_pipe;

	////////////////////////////////////////////////////////////
	// raster counters
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_6m) begin
		if (!rst_n) begin
			h_count <= '0;
			v_count <= '0;
		end else if (h_count == tilegen_pkg::coord_t'(tilegen_pkg::H_TOTAL - 1)) begin
			h_count <= '0;
			// line done, step the frame
			if (v_count == tilegen_pkg::coord_t'(tilegen_pkg::V_TOTAL - 1))
				v_count <= '0;
			else
				v_count <= v_count + 1'b1;
		end else begin
			h_count <= h_count + 1'b1;
		end
	end

	// flip mirrors both axes of the visible area
	// blanking positions wrap around, nothing is shown there anyway
	assign layer0.fetch_x = flip ? tilegen_pkg::coord_t'(tilegen_pkg::H_ACTIVE - 1) - h_count
		: h_count;
	assign layer0.fetch_y = flip ? tilegen_pkg::coord_t'(tilegen_pkg::V_ACTIVE - 1) - v_count
		: v_count;
	// both layers walk the same raster
	assign layer1.fetch_x = layer0.fetch_x;
	assign layer1.fetch_y = layer0.fetch_y;

	////////////////////////////////////////////////////////////
	// cpu write decode
	////////////////////////////////////////////////////////////

	assign region = cpu_addr[13:12];

	// map strobes go straight through, the ram writes on this edge
	assign layer0.map_we    = cpu_we && (region == tilegen_pkg::REGION_MAP0);
	assign layer0.map_addr  = cpu_addr[9:0];
	assign layer0.map_wdata = cpu_wdata;
	assign layer1.map_we    = cpu_we && (region == tilegen_pkg::REGION_MAP1);
	assign layer1.map_addr  = cpu_addr[9:0];
	assign layer1.map_wdata = cpu_wdata;

	// one pixel per pattern address, low three data bits
	assign pattern_we    = cpu_we && (region == tilegen_pkg::REGION_PATTERN);
	assign pattern_addr  = cpu_addr[11:0];
	assign pattern_wdata = cpu_wdata[2:0];

	// register file, visible to the datapath one clock after the write
	always_ff @(posedge clk_6m) begin
		if (!rst_n) begin
			scroll0_x  <= '0;
			scroll0_y  <= '0;
			scroll1_x  <= '0;
			scroll1_y  <= '0;
			back_color <= '0;
			flip       <= 1'b0;
		end else if (cpu_we && (region == tilegen_pkg::REGION_REGS)) begin
			case (cpu_addr[2:0])
				tilegen_pkg::REG_SCROLL0_X: scroll0_x  <= cpu_wdata[7:0];
				tilegen_pkg::REG_SCROLL0_Y: scroll0_y  <= cpu_wdata[7:0];
				tilegen_pkg::REG_SCROLL1_X: scroll1_x  <= cpu_wdata[7:0];
				tilegen_pkg::REG_SCROLL1_Y: scroll1_y  <= cpu_wdata[7:0];
				tilegen_pkg::REG_BACKCOLOR: back_color <= cpu_wdata[7:0];
				tilegen_pkg::REG_FLIP:      flip       <= cpu_wdata[0];
				default: ;
			endcase
		end
	end

	assign layer0.scroll_x = scroll0_x;
	assign layer0.scroll_y = scroll0_y;
	assign layer1.scroll_x = scroll1_x;
	assign layer1.scroll_y = scroll1_y;

	////////////////////////////////////////////////////////////
	// timing outputs, delayed to line up with dot
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_6m) begin
		if (!rst_n) begin
			de_pipe <= '0;
			hs_pipe <= '0;
			vs_pipe <= '0;
		end else begin
			de_pipe <= {de_pipe[tilegen_pkg::PIPE_LATENCY-2:0],
				(h_count < tilegen_pkg::H_ACTIVE) && (v_count < tilegen_pkg::V_ACTIVE)};
			hs_pipe <= {hs_pipe[tilegen_pkg::PIPE_LATENCY-2:0],
				(h_count >= tilegen_pkg::HSYNC_START) && (h_count < tilegen_pkg::HSYNC_END)};
			vs_pipe <= {vs_pipe[tilegen_pkg::PIPE_LATENCY-2:0],
				(v_count >= tilegen_pkg::VSYNC_START) && (v_count < tilegen_pkg::VSYNC_END)};
		end
	end

	assign de    = de_pipe[tilegen_pkg::PIPE_LATENCY-1];
	assign hsync = hs_pipe[tilegen_pkg::PIPE_LATENCY-1];
	assign vsync = vs_pipe[tilegen_pkg::PIPE_LATENCY-1];

endmodule

// ==== hdl/tilegen_pkg.sv ====
package tilegen_pkg;

	////////////////////////////////////////////////////////////
	// video timing, one dot per clk_6m
	////////////////////////////////////////////////////////////

	localparam int H_ACTIVE    = 256;
	localparam int H_TOTAL     = 320;
	localparam int V_ACTIVE    = 224;
	localparam int V_TOTAL     = 240;
	localparam int HSYNC_START = 272;
	localparam int HSYNC_END   = 288;
	localparam int VSYNC_START = 228;
	localparam int VSYNC_END   = 231;
	// counter position to registered dot
	localparam int PIPE_LATENCY = 3;

	////////////////////////////////////////////////////////////
	// pixel rules and cpu address map
	////////////////////////////////////////////////////////////

	// pattern value that lets the layer below show through
	localparam int TRANSPARENT_PIXEL = 7;

	// cpu_addr[13:12] selects the region
	localparam logic [1:0] REGION_MAP0    = 2'd0;
	localparam logic [1:0] REGION_MAP1    = 2'd1;
	localparam logic [1:0] REGION_PATTERN = 2'd2;
	localparam logic [1:0] REGION_REGS    = 2'd3;

	// register offsets, cpu_addr[2:0] inside the register region
	localparam logic [2:0] REG_SCROLL0_X  = 3'd0;
	localparam logic [2:0] REG_SCROLL0_Y  = 3'd1;
	localparam logic [2:0] REG_SCROLL1_X  = 3'd2;
	localparam logic [2:0] REG_SCROLL1_Y  = 3'd3;
	localparam logic [2:0] REG_BACKCOLOR  = 3'd4;
	localparam logic [2:0] REG_FLIP       = 3'd5;

	// tilemap word layout
	localparam int ENTRY_CODE_LSB     = 0;
	localparam int ENTRY_PALETTE_LSB  = 8;
	localparam int ENTRY_PRIORITY_BIT = 13;

	typedef logic [13:0] cpu_addr_t;
	typedef logic [15:0] cpu_data_t;
	typedef logic [15:0] map_entry_t;
	typedef logic [5:0]  tile_code_t;
	typedef logic [4:0]  palette_t;
	typedef logic [2:0]  pixel_t;
	typedef logic [7:0]  dot_t;
	typedef logic [8:0]  coord_t;
	// tilemap plane is 256 x 256, so scroll wraps at 8 bits
	typedef logic [7:0]  scroll_t;
	typedef logic [9:0]  map_addr_t;
	typedef logic [11:0] pattern_addr_t;

endpackage

// ==== hdl/tilegen_subsystem.sv ====
`timescale 1ns/100ps

module tilegen_subsystem (
	input  logic                   clk_6m,
	input  logic                   rst_n,
	input  tilegen_pkg::cpu_addr_t cpu_addr,
	input  logic                   cpu_we,
	input  tilegen_pkg::cpu_data_t cpu_wdata,
	output tilegen_pkg::dot_t      dot,
	output logic                   de,
	output logic                   hsync,
	output logic                   vsync
);

	layer_ctrl_if layer0_ctrl ();
	layer_ctrl_if layer1_ctrl ();
	tile_fetch_if layer0_fetch ();
	tile_fetch_if layer1_fetch ();

	logic                       pattern_we;
	tilegen_pkg::pattern_addr_t pattern_addr;
	tilegen_pkg::pixel_t        pattern_wdata;
	tilegen_pkg::dot_t          back_color;

	// layer outputs into the mixer, all at stage 2
	tilegen_pkg::pixel_t   pixel0;
	tilegen_pkg::palette_t palette0;
	logic                  priority0;
	tilegen_pkg::pixel_t   pixel1;
	tilegen_pkg::palette_t palette1;
	logic                  priority1;

	tilegen_control u_control (
		.clk_6m        (clk_6m),
		.rst_n         (rst_n),
		.cpu_addr      (cpu_addr),
		.cpu_we        (cpu_we),
		.cpu_wdata     (cpu_wdata),
		.layer0        (layer0_ctrl.control),
		.layer1        (layer1_ctrl.control),
		.pattern_we    (pattern_we),
		.pattern_addr  (pattern_addr),
		.pattern_wdata (pattern_wdata),
		.back_color    (back_color),
		.de            (de),
		.hsync         (hsync),
		.vsync         (vsync)
	);

	// front layer pair, both in lockstep on the same raster
	tile_layer u_layer0 (
		.clk_6m       (clk_6m),
		.ctrl         (layer0_ctrl.layer),
		.fetch        (layer0_fetch.request),
		.pixel        (pixel0),
		.palette      (palette0),
		.priority_bit (priority0)
	);

	tile_layer u_layer1 (
		.clk_6m       (clk_6m),
		.ctrl         (layer1_ctrl.layer),
		.fetch        (layer1_fetch.request),
		.pixel        (pixel1),
		.palette      (palette1),
		.priority_bit (priority1)
	);

	tile_pattern u_pattern (
		.clk_6m        (clk_6m),
		.pattern_we    (pattern_we),
		.pattern_addr  (pattern_addr),
		.pattern_wdata (pattern_wdata),
		.fetch0        (layer0_fetch.lookup),
		.fetch1        (layer1_fetch.lookup)
	);

	layer_mixer u_mixer (
		.clk_6m     (clk_6m),
		.rst_n      (rst_n),
		.pixel0     (pixel0),
		.palette0   (palette0),
		.priority0  (priority0),
		.pixel1     (pixel1),
		.palette1   (palette1),
		.priority1  (priority1),
		.back_color (back_color),
		.dot        (dot)
	);

endmodule

// ==== list.f ====
hdl/tilegen_pkg.sv
hdl/layer_ctrl_if.sv
hdl/tile_fetch_if.sv
hdl/tilegen_control.sv
hdl/tile_layer.sv
hdl/tile_pattern.sv
hdl/layer_mixer.sv
hdl/tilegen_subsystem.sv
testbench/tilegen_assertions.sv
testbench/tb_tilegen.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile the tile generator testbench with Verilator and run it
# the exit status is that of the failing step, or 0 when both pass

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_tilegen \
	-f list.f \
	-o sim_tilegen
status=$?
if [ $status -ne 0 ]; then
	echo "build failed with status $status"
	exit $status
fi

./obj_dir/sim_tilegen
status=$?
if [ $status -ne 0 ]; then
	echo "simulation ended with status $status"
	exit $status
fi

exit 0

// ==== testbench/tb_tilegen.sv ====
`timescale 1ns/100ps

module tb_tilegen;

	// one table row, writes applied then one probe of the next frame
	typedef struct {
		string      name;
		logic [7:0] s0x;
		logic [7:0] s0y;
		logic [7:0] s1x;
		logic [7:0] s1y;
		logic [7:0] back;
		logic       flip;
		logic       map_layer;
		logic [9:0] map_addr;
		logic [15:0] map_data;
		logic [11:0] pat_addr;
		logic [2:0] pat_data;
		int         px;
		int         py;
		// -1 takes the value from the model
		int         exp;
	} row_t;

	logic                   clk_6m;
	logic                   rst_n;
	tilegen_pkg::cpu_addr_t cpu_addr;
	logic                   cpu_we;
	tilegen_pkg::cpu_data_t cpu_wdata;
	tilegen_pkg::dot_t      dot;
	logic                   de;
	logic                   hsync;
	logic                   vsync;

	// mirrors of what the cpu side wrote
	logic [15:0] map_mirror [2][1024];
	logic [2:0]  pat_mirror [4096];
	logic [31:0] lcg_state = 32'hb4ad754d;
	int          r;
	int          count;
	int          actual;
	int          expected;

	// layer 0 random fill has no priority bits, so rows place them on purpose
	// pattern code 0 is fully transparent
	row_t rows [10] = '{
		'{"layer0_plain", 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 1'b0, 1'b0, 10'd67,
			16'h0c0b, 12'd737, 3'd6, 25, 20, -1},
		'{"layer1_plain", 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 1'b0, 1'b1, 10'd67,
			16'h050a, 12'd673, 3'd3, 25, 20, 43},
		'{"layer0_priority", 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 1'b0, 1'b0, 10'd67,
			16'h2c0b, 12'd737, 3'd6, 25, 20, 102},
		'{"layer0_transparent", 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 1'b0, 1'b0, 10'd67,
			16'h2c00, 12'd673, 3'd3, 25, 20, 43},
		'{"back_color", 8'h00, 8'h00, 8'h00, 8'h00, 8'h5a, 1'b0, 1'b1, 10'd67,
			16'h0500, 12'd737, 3'd6, 25, 20, 90},
		'{"scroll0_wrap", 8'h10, 8'hf8, 8'h00, 8'h00, 8'h5a, 1'b0, 1'b0, 10'd52,
			16'h230c, 12'd814, 3'd2, 150, 21, 26},
		'{"scroll1_wrap", 8'h00, 8'h00, 8'hf0, 8'h20, 8'h5a, 1'b0, 1'b1, 10'd225,
			16'h1d0d, 12'd855, 3'd1, 31, 26, 233},
		'{"flip_mirror", 8'h00, 8'h00, 8'h00, 8'h00, 8'h5a, 1'b1, 1'b1, 10'd67,
			16'h050a, 12'd673, 3'd3, 230, 203, 43},
		'{"random_scroll", 8'h37, 8'h91, 8'hc4, 8'h0b, 8'h11, 1'b0, 1'b0, 10'd500,
			16'h1234, 12'd100, 3'd5, 200, 150, -1},
		'{"random_flip", 8'h05, 8'he2, 8'h7a, 8'h66, 8'h3c, 1'b1, 1'b1, 10'd777,
			16'h2a15, 12'd2047, 3'd0, 17, 211, -1}
	};

	tilegen_subsystem i_tilegen_subsystem (
		.clk_6m    (clk_6m),
		.rst_n     (rst_n),
		.cpu_addr  (cpu_addr),
		.cpu_we    (cpu_we),
		.cpu_wdata (cpu_wdata),
		.dot       (dot),
		.de        (de),
		.hsync     (hsync),
		.vsync     (vsync)
	);

	initial begin
		clk_6m = 1'b0;
		forever #50 clk_6m = ~clk_6m;
	end

	////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic check_value(input string name, input int exp_val, input int act_val);
		if (exp_val !== act_val) begin
			$display("Mismatch %s expected %0d actual %0d", name, exp_val, act_val);
			$display("Something failed");
			$fatal(1, "check %s did not match", name);
		end
	endtask

	// call at a falling edge, cpu_we stays high until the caller drops it
	task automatic cpu_write(input tilegen_pkg::cpu_addr_t addr,
		input tilegen_pkg::cpu_data_t data);
		cpu_addr  = addr;
		cpu_wdata = data;
		cpu_we    = 1'b1;
		@(negedge clk_6m);
	endtask

	function automatic tilegen_pkg::cpu_addr_t map_cpu_addr(input logic layer, input int idx);
		return {layer ? tilegen_pkg::REGION_MAP1 : tilegen_pkg::REGION_MAP0, 2'b00, 10'(idx)};
	endfunction

	function automatic tilegen_pkg::cpu_addr_t reg_cpu_addr(input logic [2:0] offset);
		return {tilegen_pkg::REGION_REGS, 9'd0, offset};
	endfunction

	// {priority, palette, pixel} of one layer at a fetch position
	function automatic logic [8:0] layer_lookup(input int layer, input int fx, input int fy,
		input int sx, input int sy);
		int          mx;
		int          my;
		logic [15:0] entry;
		logic [2:0]  pix;
		mx    = (fx + sx) % 256;
		my    = (fy + sy) % 256;
		entry = map_mirror[layer][(my / 8) * 32 + mx / 8];
		pix   = pat_mirror[int'(entry[5:0]) * 64 + (my % 8) * 8 + mx % 8];
		return {entry[13], entry[12:8], pix};
	endfunction

	// reference dot for a screen position under one row's settings
	function automatic int model_dot(input row_t row);
		int         fx;
		int         fy;
		logic [8:0] l0;
		logic [8:0] l1;
		fx = row.flip ? tilegen_pkg::H_ACTIVE - 1 - row.px : row.px;
		fy = row.flip ? tilegen_pkg::V_ACTIVE - 1 - row.py : row.py;
		l0 = layer_lookup(0, fx, fy, int'(row.s0x), int'(row.s0y));
		l1 = layer_lookup(1, fx, fy, int'(row.s1x), int'(row.s1y));
		// winning layer shows palette * 8 + pixel
		if (l0[2:0] != 3'd7 && l0[8])
			return int'(l0[7:3]) * 8 + int'(l0[2:0]);
		else if (l1[2:0] != 3'd7)
			return int'(l1[7:3]) * 8 + int'(l1[2:0]);
		else if (l0[2:0] != 3'd7)
			return int'(l0[7:3]) * 8 + int'(l0[2:0]);
		return int'(row.back);
	endfunction

	task automatic fill_memories();
		logic [15:0] entry;
		logic [2:0]  pix;
		@(negedge clk_6m);
		for (int i = 0; i < 1024; i++) begin
			lcg_state = lcg_next(lcg_state);
			entry = lcg_state[31:16] & 16'h1f3f;
			map_mirror[0][i] = entry;
			cpu_write(map_cpu_addr(1'b0, i), entry);
		end
		for (int i = 0; i < 1024; i++) begin
			lcg_state = lcg_next(lcg_state);
			entry = lcg_state[31:16] & 16'h3f3f;
			map_mirror[1][i] = entry;
			cpu_write(map_cpu_addr(1'b1, i), entry);
		end
		for (int i = 0; i < 4096; i++) begin
			lcg_state = lcg_next(lcg_state);
			pix = (i < 64) ? 3'd7 : lcg_state[18:16];
			pat_mirror[i] = pix;
			cpu_write({tilegen_pkg::REGION_PATTERN, 12'(i)}, {13'd0, pix});
		end
		cpu_we = 1'b0;
	endtask

	task automatic apply_row(input row_t row);
		@(negedge clk_6m);
		cpu_write(reg_cpu_addr(tilegen_pkg::REG_SCROLL0_X), {8'h00, row.s0x});
		cpu_write(reg_cpu_addr(tilegen_pkg::REG_SCROLL0_Y), {8'h00, row.s0y});
		cpu_write(reg_cpu_addr(tilegen_pkg::REG_SCROLL1_X), {8'h00, row.s1x});
		cpu_write(reg_cpu_addr(tilegen_pkg::REG_SCROLL1_Y), {8'h00, row.s1y});
		cpu_write(reg_cpu_addr(tilegen_pkg::REG_BACKCOLOR), {8'h00, row.back});
		cpu_write(reg_cpu_addr(tilegen_pkg::REG_FLIP), {15'd0, row.flip});
		cpu_write(map_cpu_addr(row.map_layer, int'(row.map_addr)), row.map_data);
		cpu_write({tilegen_pkg::REGION_PATTERN, row.pat_addr}, {13'd0, row.pat_data});
		cpu_we = 1'b0;
		map_mirror[row.map_layer][row.map_addr] = row.map_data;
		pat_mirror[row.pat_addr] = row.pat_data;
	endtask

	task automatic wait_vsync_fall();
		logic prev;
		logic done;
		prev = vsync;
		done = 1'b0;
		while (!done) begin
			@(negedge clk_6m);
			done = prev && !vsync;
			prev = vsync;
		end
	endtask

	// de-high pixels come in raster order from the frame start
	task automatic probe_dot(input int x, input int y, output int value);
		int   target;
		int   seen;
		logic found;
		target = y * tilegen_pkg::H_ACTIVE + x;
		seen   = 0;
		found  = 1'b0;
		while (!found) begin
			@(negedge clk_6m);
			if (de) begin
				if (seen == target)
					found = 1'b1;
				else
					seen++;
			end
		end
		value = int'(dot);
	endtask

	task automatic count_frame_pixels(output int pixels);
		wait_vsync_fall();
		pixels = 0;
		@(negedge clk_6m);
		while (!vsync) begin
			if (de)
				pixels++;
			@(negedge clk_6m);
		end
	endtask

	////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////

	initial begin
		rst_n     = 1'b0;
		cpu_we    = 1'b0;
		cpu_addr  = '0;
		cpu_wdata = '0;
		repeat (16) @(posedge clk_6m);
		@(negedge clk_6m);
		check_value("reset_outputs", 0, int'({de, hsync, vsync}));
		rst_n = 1'b1;

		fill_memories();
		count_frame_pixels(count);
		check_value("frame_de_count", tilegen_pkg::H_ACTIVE * tilegen_pkg::V_ACTIVE, count);

		for (r = 0; r < $size(rows); r++) begin
			apply_row(rows[r]);
			wait_vsync_fall();
			probe_dot(rows[r].px, rows[r].py, actual);
			expected = model_dot(rows[r]);
			// directed rows also confirm the model agrees
			if (rows[r].exp >= 0) begin
				check_value({rows[r].name, "_model"}, rows[r].exp, expected);
				expected = rows[r].exp;
			end
			check_value(rows[r].name, expected, actual);
		end

		$display("Everything OK");
		$finish;
	end

	// setup and the frame count take about two rows worth of frames
	initial begin
		int limit;
		limit = ($size(rows) + 2) * 2 * tilegen_pkg::H_TOTAL * tilegen_pkg::V_TOTAL;
		repeat (limit) @(posedge clk_6m);
		$display("Timeout, the run did not finish within %0d clocks", limit);
		$display("Something failed");
		$fatal(1, "watchdog expired");
	end

endmodule

// ==== testbench/tilegen_assertions.sv ====
`timescale 1ns/100ps

// timing output checks, bound into the control block
module tilegen_assertions (
	input logic clk_6m,
	input logic rst_n,
	input logic de,
	input logic hsync,
	input logic vsync
);

	// length of the current hsync pulse
	logic [8:0] hs_len;

	always_ff @(posedge clk_6m) begin
		if (!rst_n)
			hs_len <= '0;
		else if (hsync)
			hs_len <= hs_len + 1'b1;
		else
			hs_len <= '0;
	end

	////////////////////////////////////////////////////////////
	// reset and overlap
	////////////////////////////////////////////////////////////

	// sync reset clears the delay line on the first edge
	a_reset_quiet: assert property (@(posedge clk_6m)
		!rst_n |=> (!de && !hsync && !vsync))
		else $error("timing outputs not low during reset");

	// active video never overlaps a sync pulse
	a_de_no_sync: assert property (@(posedge clk_6m) disable iff (!rst_n)
		!(de && (hsync || vsync)))
		else $error("de high together with a sync pulse");

	// counter holds the pulse length at the falling edge
	a_hsync_width: assert property (@(posedge clk_6m) disable iff (!rst_n)
		$fell(hsync) |-> (hs_len == 9'(tilegen_pkg::HSYNC_END - tilegen_pkg::HSYNC_START)))
		else $error("hsync pulse has the wrong width");

endmodule

bind tilegen_control tilegen_assertions u_assertions (.*);
